//--- logic/cache_consts.svh
/*
  Fixed geometry of the L1 data cache and its memory bus.
  The address split has to add up to ADDR_BITS, so these values are not independent.
*/
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Associativity and set count
`define CACHE_WAYS 4
`define CACHE_SETS 32

// Address split: tag, index, byte offset
`define ADDR_BITS 64
`define INDEX_BITS 5
`define OFFSET_BITS 6
`define TAG_BITS 53

// One line is 64 bytes
`define LINE_BYTES 64

// Memory bus widths
`define BUS_DATA_BITS 64
`define BUS_TAG_BITS 13
`define BEATS_PER_LINE 8

// Request and response tag codes
`define BUS_TAG_READ 13'h1100
`define BUS_TAG_WRITE 13'h0100

`endif

//--- logic/mem_op_pkg.sv
/*
  Load and store operation codes with their size and sign classification.
*/
package mem_op_pkg;

  typedef enum logic [3:0] {
    LD  = 4'd0,
    LW  = 4'd1,
    LH  = 4'd2,
    LB  = 4'd3,
    LWU = 4'd4,
    LHU = 4'd5,
    LBU = 4'd6,
    SD  = 4'd7,
    SW  = 4'd8,
    SH  = 4'd9,
    SB  = 4'd10
  } mem_op_t;

  // Access size in bytes
  function automatic logic [3:0] op_size(input mem_op_t op);
    case (op)
      LD, SD:       return 4'd8;
      LW, LWU, SW:  return 4'd4;
      LH, LHU, SH:  return 4'd2;
      default:      return 4'd1;
    endcase
  endfunction

  // Loads that copy the top bit upward
  function automatic logic op_signed(input mem_op_t op);
    return op inside {LW, LH, LB};
  endfunction

  // Stores merge into the line
  function automatic logic op_is_store(input mem_op_t op);
    return op inside {SD, SW, SH, SB};
  endfunction

endpackage

//--- logic/cache_line_pkg.sv
/*
  Address fields and line views that the cache RTL shares.
  A line is read either as bus beats or as bytes. Both views alias the same 512 bits.
*/
`include "cache_consts.svh"

package cache_line_pkg;

  // Address fields
  typedef logic [`TAG_BITS-1:0] line_tag_t;
  typedef logic [`INDEX_BITS-1:0] set_index_t;

  // Full byte address, tag in the upper bits
  typedef struct packed {
    line_tag_t                tag;
    set_index_t               index;
    logic [`OFFSET_BITS-1:0]  offset;
  } cache_addr_t;

  // Beat view for bus transfers and doublewords, byte view for sub-word access
  // Beat 0 and byte 0 both sit at the lowest address
  typedef union packed {
    logic [`BEATS_PER_LINE-1:0][`BUS_DATA_BITS-1:0] beats;
    logic [`LINE_BYTES-1:0][7:0]                     bytes;
  } cache_line_u;

  // Way number within a set
  typedef logic [1:0] way_sel_t;

endpackage

//--- logic/cache_way.sv
/*
  One way: tag, valid, dirty and line per set.
  Reads are asynchronous at set_index. One set is written per clock edge.
*/
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_way import cache_line_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  set_index_t  set_index,
  input  logic        write,
  input  line_tag_t   write_tag,
  input  cache_line_u write_line,
  input  logic        write_dirty,
  output logic        valid,
  output logic        dirty,
  output line_tag_t   tag,
  output cache_line_u line
);

  // Per-set state bits
  logic [`CACHE_SETS-1:0] valid_bits;
  logic [`CACHE_SETS-1:0] dirty_bits;

  // Tag and data arrays
  line_tag_t   tag_mem  [`CACHE_SETS];
  cache_line_u line_mem [`CACHE_SETS];

  // Valid and dirty start clear
  always_ff @(posedge clk) begin
    if (!reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (write) begin
      valid_bits[set_index] <= 1'b1;
      dirty_bits[set_index] <= write_dirty;
    end
  end

  // Fill or store merge replaces the whole line
  always_ff @(posedge clk) begin
    if (write) begin
      tag_mem[set_index]  <= write_tag;
      line_mem[set_index] <= write_line;
    end
  end

  // Asynchronous read of the addressed set
  assign valid = valid_bits[set_index];
  assign dirty = dirty_bits[set_index];
  assign tag   = tag_mem[set_index];
  assign line  = line_mem[set_index];

  // The request FSM must stay quiet while reset is held
  a_no_write_in_reset: assert property (@(posedge clk) !reset |-> !write)
    else $error("cache_way written during reset");

endmodule

//--- logic/cache_request.sv
/*
  Request front end. Holds one request at a time, req is only legal while busy is low.
  Addresses are assumed naturally aligned to the access size.
*/
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_request import cache_line_pkg::*, mem_op_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  mem_op_t                 op,
  input  cache_addr_t             addr,
  input  logic [63:0]             wdata,
  input  logic                    hit,
  input  way_sel_t                hit_way,
  input  way_sel_t                victim_way,
  input  logic                    victim_dirty,
  input  line_tag_t               victim_tag,
  input  logic [63:0]             load_value,
  input  cache_line_u             store_line,
  input  logic                    fill_done,
  input  cache_line_u             fill_line,
  output logic                    busy,
  output logic                    done,
  output logic [63:0]             rdata,
  output set_index_t              set_index,
  output line_tag_t               req_tag,
  output mem_op_t                 req_op,
  output logic [5:0]              req_offset,
  output logic [63:0]             req_wdata,
  output logic [`CACHE_WAYS-1:0]  way_write,
  output cache_line_u             write_line,
  output logic                    write_dirty,
  output logic                    xfer_start,
  output logic [63:0]             wb_addr,
  output logic                    wb_needed,
  output logic [63:0]             fill_addr,
  output logic                    advance_victim
);

  localparam logic [1:0] IDLE      = 2'd0;
  localparam logic [1:0] LOOKUP    = 2'd1;
  localparam logic [1:0] WAIT_FILL = 2'd2;
  localparam logic [1:0] REPLAY    = 2'd3;

  logic [1:0]   state;
  cache_addr_t  req_addr;
  logic         is_store;
  logic         lookup_hit;
  logic         write_en;
  way_sel_t     write_way;

  // Latched request drives every way
  assign set_index  = req_addr.index;
  assign req_tag    = req_addr.tag;
  assign req_offset = req_addr.offset;
  assign busy       = state != IDLE;
  assign is_store   = op_is_store(req_op);

  // Lookup and replay both finish on a hit
  assign lookup_hit     = (state == LOOKUP || state == REPLAY) && hit;
  // Miss decided once, in the first lookup cycle
  assign xfer_start     = state == LOOKUP && !hit;
  assign advance_victim = state == WAIT_FILL && fill_done;

  // Write source: fill goes in clean, store merge goes in dirty
  assign write_en    = (lookup_hit && is_store) || advance_victim;
  assign write_way   = advance_victim ? victim_way : hit_way;
  assign write_line  = advance_victim ? fill_line : store_line;
  assign write_dirty = !advance_victim;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      way_write[w] = write_en && (write_way == way_sel_t'(w));
    end
  end

  // Line-aligned addresses for the bus engine
  assign wb_addr   = {victim_tag, req_addr.index, {`OFFSET_BITS{1'b0}}};
  assign wb_needed = victim_dirty;
  assign fill_addr = {req_addr.tag, req_addr.index, {`OFFSET_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      done <= lookup_hit;
      case (state)
        IDLE:      if (req) state <= LOOKUP;
        LOOKUP:    state <= hit ? IDLE : WAIT_FILL;
        WAIT_FILL: if (fill_done) state <= REPLAY;
        default:   state <= IDLE;
      endcase
    end
  end

  // Request and result registers
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      req_op    <= op;
      req_addr  <= addr;
      req_wdata <= wdata;
    end
    // Stores answer with zero
    if (lookup_hit) begin
      rdata <= is_store ? 64'd0 : load_value;
    end
  end

  a_req_not_busy: assert property (@(posedge clk) disable iff (!reset) req |-> !busy)
    else $error("req arrived while the cache was busy");

endmodule

//--- logic/hit_select.sv
/*
  Tag compare, victim choice and load/store data path, all combinational.
  Victim is the lowest invalid way, else the round-robin pointer, which moves after each fill.
*/
`timescale 1ns/1ps
`include "cache_consts.svh"

module hit_select import cache_line_pkg::*, mem_op_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset,
  input  line_tag_t                            req_tag,
  input  mem_op_t                              req_op,
  input  logic [5:0]                           req_offset,
  input  logic [63:0]                          req_wdata,
  input  logic [`CACHE_WAYS-1:0]               way_valid,
  input  logic [`CACHE_WAYS-1:0]               way_dirty,
  input  line_tag_t [`CACHE_WAYS-1:0]          way_tag,
  input  cache_line_u [`CACHE_WAYS-1:0]        way_line,
  input  logic                                 advance_victim,
  output logic                                 hit,
  output way_sel_t                             hit_way,
  output way_sel_t                             victim_way,
  output logic                                 victim_dirty,
  output line_tag_t                            victim_tag,
  output cache_line_u                          victim_line,
  output logic [63:0]                          load_value,
  output cache_line_u                          store_line
);

  logic [`CACHE_WAYS-1:0] way_match;
  way_sel_t               rr_ptr;
  way_sel_t               free_way;
  logic                   any_free;
  cache_line_u            hit_line;
  logic [3:0]             size;
  logic [7:0]             msb_byte;
  logic                   sign_bit;

  // Hit search, then lowest invalid way
  always_comb begin
    hit      = 1'b0;
    hit_way  = '0;
    any_free = 1'b0;
    free_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      way_match[w] = way_valid[w] && (way_tag[w] == req_tag);
      if (way_match[w]) begin
        hit     = 1'b1;
        hit_way = way_sel_t'(w);
      end
    end
    // Descending scan leaves the lowest invalid way
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!way_valid[w]) begin
        any_free = 1'b1;
        free_way = way_sel_t'(w);
      end
    end
  end

  assign victim_way   = any_free ? free_way : rr_ptr;
  assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
  assign victim_tag   = way_tag[victim_way];
  assign victim_line  = way_line[victim_way];

  // Byte view at the request offset
  assign hit_line = way_line[hit_way];
  assign size     = op_size(req_op);
  assign msb_byte = hit_line.bytes[req_offset + 6'(size) - 6'd1];
  assign sign_bit = op_signed(req_op) && msb_byte[7];

  // Low bytes from the line, upper bytes from the sign
  // Store bytes overwrite the same positions of the hit line
  always_comb begin
    load_value = '0;
    store_line = hit_line;
    for (int b = 0; b < 8; b++) begin
      if (4'(b) < size) begin
        load_value[8*b +: 8] = hit_line.bytes[req_offset + 6'(b)];
        store_line.bytes[req_offset + 6'(b)] = req_wdata[8*b +: 8];
      end else begin
        load_value[8*b +: 8] = {8{sign_bit}};
      end
    end
  end

  // Pointer moves once per fill
  always_ff @(posedge clk) begin
    if (!reset) begin
      rr_ptr <= '0;
    end else if (advance_victim) begin
      rr_ptr <= rr_ptr + 2'd1;
    end
  end

  // Fills only go to a missing tag, so a tag lives in one way
  a_single_hit: assert property (@(posedge clk) disable iff (!reset) $onehot0(way_match))
    else $error("more than one way hit");

endmodule

//--- logic/line_transfer.sv
/*
  Bus engine for one miss: optional writeback, then the line fill.
  Writeback is an address beat plus eight data beats, fill is one address beat.
  Response beats with a tag other than BUS_TAG_READ are dropped.
*/
`timescale 1ns/1ps
`include "cache_consts.svh"

module line_transfer import cache_line_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       xfer_start,
  input  logic                       wb_needed,
  input  logic [63:0]                wb_addr,
  input  cache_line_u                victim_line,
  input  logic [63:0]                fill_addr,
  input  logic                       bus_reqack,
  input  logic                       bus_respcyc,
  input  logic [`BUS_DATA_BITS-1:0]  bus_resp,
  input  logic [`BUS_TAG_BITS-1:0]   bus_resptag,
  output logic                       bus_reqcyc,
  output logic [`BUS_DATA_BITS-1:0]  bus_req,
  output logic [`BUS_TAG_BITS-1:0]   bus_reqtag,
  output logic                       bus_respack,
  output logic                       fill_done,
  output cache_line_u                fill_line
);

  localparam logic [2:0] IDLE    = 3'd0;
  localparam logic [2:0] WB_ADDR = 3'd1;
  localparam logic [2:0] WB_DATA = 3'd2;
  localparam logic [2:0] RD_ADDR = 3'd3;
  localparam logic [2:0] RD_DATA = 3'd4;

  logic [2:0] state;
  logic [2:0] beat;
  logic       last_beat;
  logic       resp_take;

  assign last_beat = beat == 3'(`BEATS_PER_LINE - 1);
  // A response beat counts on respcyc and respack with a read tag
  assign resp_take = bus_respcyc && bus_respack && (bus_resptag == `BUS_TAG_READ);

  // Control: state, beat count, cyc and ack levels
  always_ff @(posedge clk) begin
    if (!reset) begin
      state       <= IDLE;
      beat        <= '0;
      bus_reqcyc  <= 1'b0;
      bus_respack <= 1'b0;
      fill_done   <= 1'b0;
    end else begin
      fill_done <= 1'b0;
      case (state)
        IDLE: begin
          beat <= '0;
          if (xfer_start) begin
            bus_reqcyc <= 1'b1;
            state      <= wb_needed ? WB_ADDR : RD_ADDR;
          end
        end
        WB_ADDR: if (bus_reqack) state <= WB_DATA;
        WB_DATA: begin
          // Counter wraps to zero for the fill
          if (bus_reqack) begin
            beat <= beat + 3'd1;
            if (last_beat) state <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          // Request side done, start collecting
          if (bus_reqack) begin
            bus_reqcyc  <= 1'b0;
            bus_respack <= 1'b1;
            state       <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (resp_take) begin
            beat <= beat + 3'd1;
            if (last_beat) begin
              bus_respack <= 1'b0;
              fill_done   <= 1'b1;
              state       <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Beat payloads, held until acked
  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (xfer_start) begin
          bus_req    <= wb_needed ? wb_addr : fill_addr;
          bus_reqtag <= wb_needed ? `BUS_TAG_WRITE : `BUS_TAG_READ;
        end
      end
      WB_ADDR: if (bus_reqack) bus_req <= victim_line.beats[0];
      WB_DATA: begin
        if (bus_reqack) begin
          if (last_beat) begin
            bus_req    <= fill_addr;
            bus_reqtag <= `BUS_TAG_READ;
          end else begin
            bus_req <= victim_line.beats[beat + 3'd1];
          end
        end
      end
      // Lowest beat first
      RD_DATA: if (resp_take) fill_line.beats[beat] <= bus_resp;
      default: ;
    endcase
  end

  a_reqcyc_held: assert property (@(posedge clk) disable iff (!reset)
    bus_reqcyc && !bus_reqack |=> bus_reqcyc)
    else $error("bus_reqcyc dropped before bus_reqack");

endmodule

//--- logic/cache_l1.sv
/*
  4-way 8 KB L1 data cache with 64-byte lines on a cyc/ack memory bus.
  One request in flight, misses stall until the fill has been replayed.
*/
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_l1 import cache_line_pkg::*, mem_op_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  mem_op_t                    op,
  input  cache_addr_t                addr,
  input  logic [63:0]                wdata,
  output logic                       busy,
  output logic                       done,
  output logic [63:0]                rdata,
  output logic                       bus_reqcyc,
  input  logic                       bus_reqack,
  output logic [`BUS_DATA_BITS-1:0]  bus_req,
  output logic [`BUS_TAG_BITS-1:0]   bus_reqtag,
  input  logic                       bus_respcyc,
  output logic                       bus_respack,
  input  logic [`BUS_DATA_BITS-1:0]  bus_resp,
  input  logic [`BUS_TAG_BITS-1:0]   bus_resptag
);

  // Request to ways
  set_index_t                    set_index;
  line_tag_t                     req_tag;
  mem_op_t                       req_op;
  logic [5:0]                    req_offset;
  logic [63:0]                   req_wdata;
  logic [`CACHE_WAYS-1:0]        way_write;
  cache_line_u                   write_line;
  logic                          write_dirty;

  // Ways to hit select
  logic [`CACHE_WAYS-1:0]        way_valid;
  logic [`CACHE_WAYS-1:0]        way_dirty;
  line_tag_t [`CACHE_WAYS-1:0]   way_tag;
  cache_line_u [`CACHE_WAYS-1:0] way_line;

  // Hit select back to request
  logic        hit;
  way_sel_t    hit_way;
  way_sel_t    victim_way;
  logic        victim_dirty;
  line_tag_t   victim_tag;
  cache_line_u victim_line;
  logic [63:0] load_value;
  cache_line_u store_line;
  logic        advance_victim;

  // Miss handling
  logic        xfer_start;
  logic [63:0] wb_addr;
  logic        wb_needed;
  logic [63:0] fill_addr;
  logic        fill_done;
  cache_line_u fill_line;

  cache_request u_request (
    .clk, .reset, .req, .op, .addr, .wdata,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .load_value, .store_line, .fill_done, .fill_line,
    .busy, .done, .rdata,
    .set_index, .req_tag, .req_op, .req_offset, .req_wdata,
    .way_write, .write_line, .write_dirty,
    .xfer_start, .wb_addr, .wb_needed, .fill_addr, .advance_victim
  );

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    cache_way u_way (
      .clk, .reset, .set_index,
      .write       (way_write[w]),
      .write_tag   (req_tag),
      .write_line,
      .write_dirty,
      .valid       (way_valid[w]),
      .dirty       (way_dirty[w]),
      .tag         (way_tag[w]),
      .line        (way_line[w])
    );
  end

  hit_select u_hit (
    .clk, .reset, .req_tag, .req_op, .req_offset, .req_wdata,
    .way_valid, .way_dirty, .way_tag, .way_line, .advance_victim,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .victim_line,
    .load_value, .store_line
  );

  line_transfer u_xfer (
    .clk, .reset, .xfer_start, .wb_needed, .wb_addr, .victim_line, .fill_addr,
    .bus_reqack, .bus_respcyc, .bus_resp, .bus_resptag,
    .bus_reqcyc, .bus_req, .bus_reqtag, .bus_respack, .fill_done, .fill_line
  );

endmodule

//--- tb/cache_l1_tb.sv
/*
  Testbench for cache_l1 with a sparse memory model on the bus.
  Accesses come from tb/cache_l1_input.txt as five words per entry and end at op ff.
  Unwritten memory byte at address a reads as a[7:0] ^ 8'h5a.
*/
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_l1_tb import cache_line_pkg::*, mem_op_pkg::*; ();

  localparam int WAIT_LIMIT  = 2000;
  localparam int MAX_ENTRIES = 64;

  logic                      clk;
  logic                      reset;
  logic                      req;
  mem_op_t                   op;
  cache_addr_t               addr;
  logic [63:0]               wdata;
  logic                      busy;
  logic                      done;
  logic [63:0]               rdata;
  logic                      bus_reqcyc;
  logic                      bus_reqack;
  logic [`BUS_DATA_BITS-1:0] bus_req;
  logic [`BUS_TAG_BITS-1:0]  bus_reqtag;
  logic                      bus_respcyc;
  logic                      bus_respack;
  logic [`BUS_DATA_BITS-1:0] bus_resp;
  logic [`BUS_TAG_BITS-1:0]  bus_resptag;

  // Bus-side memory and program-order reference memory
  logic [7:0]  mem_bytes [logic [63:0]];
  logic [7:0]  ref_bytes [logic [63:0]];
  logic [63:0] resp_q [$];
  logic [63:0] vectors [0:5*MAX_ENTRIES-1];

  int          errors;
  int          wb_beat;
  int          wb_lines;
  logic [63:0] wb_base;
  logic        timed_out;

  cache_l1 dut (.*);

  always #4 clk = ~clk;

  function automatic logic [7:0] fill_byte(input logic [63:0] a);
    return a[7:0] ^ 8'h5a;
  endfunction

  // Doubleword as the memory model holds it
  function logic [63:0] mem_word(input logic [63:0] a);
    logic [63:0] w;
    logic [63:0] ba;
    for (int b = 0; b < 8; b++) begin
      ba = a + 64'(b);
      w[8*b +: 8] = mem_bytes.exists(ba) ? mem_bytes[ba] : fill_byte(ba);
    end
    return w;
  endfunction

  // Doubleword after all stores issued so far
  function logic [63:0] ref_word(input logic [63:0] a);
    logic [63:0] w;
    logic [63:0] ba;
    for (int b = 0; b < 8; b++) begin
      ba = a + 64'(b);
      w[8*b +: 8] = ref_bytes.exists(ba) ? ref_bytes[ba] : fill_byte(ba);
    end
    return w;
  endfunction

  // Beat that transfers on the coming rising edge
  task take_request_beat();
    logic [63:0] beat_addr;
    logic [63:0] line_addr;
    cache_addr_t beat_line;
    if (bus_reqtag == `BUS_TAG_READ) begin
      assert (wb_beat == 0) else begin
        $display("Fill request arrived in the middle of a writeback");
        errors++;
      end
      // Fill asks for the whole line of the current access
      line_addr = addr & ~64'(`LINE_BYTES - 1);
      assert (bus_req == line_addr) else begin
        $display("Fail bus_req fill address: got %h expected %h", bus_req, line_addr);
        errors++;
      end
      for (int i = 0; i < `BEATS_PER_LINE; i++) begin
        resp_q.push_back(mem_word(bus_req + 64'(8 * i)));
      end
    end else if (bus_reqtag == `BUS_TAG_WRITE) begin
      if (wb_beat == 0) begin
        // Victim shares the set of the access but not its tag
        beat_line = bus_req;
        assert (beat_line.offset == '0 && beat_line.index == addr.index
                && beat_line.tag != addr.tag) else begin
          $display("Writeback address %h is not another line of the accessed set", bus_req);
          errors++;
        end
        wb_base = bus_req;
        wb_beat = 1;
      end else begin
        beat_addr = wb_base + 64'(8 * (wb_beat - 1));
        assert (bus_req == ref_word(beat_addr)) else begin
          $display("Fail bus_req writeback at %h: got %h expected %h",
                   beat_addr, bus_req, ref_word(beat_addr));
          errors++;
        end
        for (int b = 0; b < 8; b++) begin
          mem_bytes[beat_addr + 64'(b)] = bus_req[8*b +: 8];
        end
        wb_beat++;
        if (wb_beat == `BEATS_PER_LINE + 1) begin
          wb_beat = 0;
          wb_lines++;
        end
      end
    end else begin
      $display("Bus request carried an unknown tag %h", bus_reqtag);
      errors++;
    end
  endtask

  // Memory model with random gaps on ack and response
  always @(negedge clk) begin
    if (!reset) begin
      bus_reqack  = 1'b0;
      bus_respcyc = 1'b0;
    end else begin
      bus_reqack = bus_reqcyc && ($urandom_range(3) != 0);
      if (bus_reqcyc && bus_reqack) take_request_beat();
      // respack only while fill beats are still owed
      assert (!bus_respack || resp_q.size() > 0) else begin
        $display("bus_respack held high with no fill beats outstanding");
        errors++;
      end
      if (resp_q.size() > 0 && $urandom_range(3) != 0) begin
        bus_respcyc = 1'b1;
        bus_resp    = resp_q[0];
        bus_resptag = `BUS_TAG_READ;
        // Taken at the next edge only if respack is already up
        if (bus_respack) void'(resp_q.pop_front());
      end else begin
        bus_respcyc = 1'b0;
      end
    end
  end

  // One access that starts and ends on a falling edge
  task issue_access(input logic [63:0] op_w, input logic [63:0] hit_w,
                    input logic [63:0] a, input logic [63:0] wd,
                    input logic [63:0] expected);
    mem_op_t o;
    int      cycles;
    int      reqs;
    int      nbytes;
    o = mem_op_t'(op_w[3:0]);
    case (o)
      SD:      nbytes = 8;
      SW:      nbytes = 4;
      SH:      nbytes = 2;
      SB:      nbytes = 1;
      default: nbytes = 0;
    endcase
    for (int b = 0; b < nbytes; b++) begin
      ref_bytes[a + 64'(b)] = wd[8*b +: 8];
    end
    assert (!busy) else begin
      $display("Cache still busy when a new request was due");
      errors++;
    end
    op    = o;
    addr  = a;
    wdata = wd;
    req   = 1'b1;
    @(negedge clk);
    req    = 1'b0;
    cycles = 1;
    reqs   = bus_reqcyc ? 1 : 0;
    while (!done && cycles < WAIT_LIMIT) begin
      assert (busy) else begin
        $display("busy fell before done at address %h", a);
        errors++;
      end
      @(negedge clk);
      cycles++;
      if (bus_reqcyc) reqs++;
    end
    if (!done) begin
      $display("Timed out waiting for done at address %h", a);
      errors++;
      timed_out = 1'b1;
      return;
    end
    if (hit_w[0]) begin
      assert (cycles == 2) else begin
        $display("Fail done latency at %h: got %h expected %h", a, cycles, 2);
        errors++;
      end
      assert (reqs == 0) else begin
        $display("Bus request seen during a hit at address %h", a);
        errors++;
      end
    end
    assert (rdata == expected) else begin
      $display("Fail rdata at %h: got %h expected %h", a, rdata, expected);
      errors++;
    end
  endtask

  initial begin
    int n;
    void'($urandom(32'h9964_3c19));
    clk         = 1'b0;
    reset       = 1'b0;
    req         = 1'b0;
    op          = LD;
    addr        = '0;
    wdata       = '0;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
    errors      = 0;
    wb_beat     = 0;
    wb_lines    = 0;
    wb_base     = '0;
    timed_out   = 1'b0;
    for (int i = 0; i < 5 * MAX_ENTRIES; i++) vectors[i] = 64'hff;
    $readmemh("tb/cache_l1_input.txt", vectors);

    repeat (2) @(posedge clk);
    @(negedge clk);
    // Request and bus handshakes idle after the reset edges
    assert (!busy && !done && !bus_reqcyc && !bus_respack) else begin
      $display("Cache outputs were not idle after reset");
      errors++;
    end
    reset = 1'b1;
    @(negedge clk);

    n = 0;
    while (n < MAX_ENTRIES && vectors[5*n] != 64'hff && !timed_out) begin
      issue_access(vectors[5*n], vectors[5*n+1], vectors[5*n+2],
                   vectors[5*n+3], vectors[5*n+4]);
      n++;
    end
    assert (n > 0) else begin
      $display("No accesses were read from the input file");
      errors++;
    end
    assert (timed_out || wb_lines > 0) else begin
      $display("No dirty line was written back");
      errors++;
    end

    $display("Accesses run: %0d, writebacks: %0d, errors: %0d", n, wb_lines, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- cache_l1.f
+incdir+logic
logic/mem_op_pkg.sv
logic/cache_line_pkg.sv
logic/cache_way.sv
logic/cache_request.sv
logic/hit_select.sv
logic/line_transfer.sv
logic/cache_l1.sv
tb/cache_l1_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache_l1 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f cache_l1.f \
  --top-module cache_l1_tb \
  -o cache_l1_sim

./obj_dir/cache_l1_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb/cache_l1_input.txt
// Columns: op hit addr wdata expected_rdata, all hex, one access per line
// op 0 LD 1 LW 2 LH 3 LB 4 LWU 5 LHU 6 LBU 7 SD 8 SW 9 SH a SB, hit 1 = must hit
0 0 1080 0 DDDCDFDED9D8DBDA
1 1 1088 0 FFFFFFFFD1D0D3D2
4 1 1088 0 00000000D1D0D3D2
2 1 1090 0 FFFFFFFFFFFFCBCA
5 1 1090 0 000000000000CBCA
3 1 1095 0 FFFFFFFFFFFFFFCF
6 1 1095 0 00000000000000CF
3 0 2021 0 000000000000007B
2 1 2022 0 0000000000007978
1 1 2024 0 000000007D7C7F7E
7 1 10A0 1122334455667788 0
0 1 10A0 0 1122334455667788
8 1 10A8 00000000CAFEF00D 0
0 1 10A8 0 F5F4F7F6CAFEF00D
9 1 10B2 000000000000BEEF 0
0 1 10B0 0 EDECEFEEBEEFEBEA
a 1 10BB 0000000000000080 0
3 1 10BB 0 FFFFFFFFFFFFFF80
6 1 10BA 0 00000000000000E0
0 0 1880 0 DDDCDFDED9D8DBDA
0 0 2080 0 DDDCDFDED9D8DBDA
0 0 2880 0 DDDCDFDED9D8DBDA
6 0 2800 0 000000000000005A
6 0 3000 0 000000000000005A
6 0 3800 0 000000000000005A
0 0 3080 0 DDDCDFDED9D8DBDA
0 0 10A0 0 1122334455667788
0 1 10A8 0 F5F4F7F6CAFEF00D
0 1 10B0 0 EDECEFEEBEEFEBEA
6 1 10BB 0 0000000000000080
9 0 5000 0000000000007F01 0
2 1 5000 0 0000000000007F01
ff 0 0 0 0
